// ==== Bender.yml ====
package:
  name: tamapet

sources:
  - hw/tamaPetPkg.sv
  - hw/petNeedsIf.sv
  - hw/buttonSync.sv
  - hw/needsKeeper.sv
  - hw/moodFsm.sv
  - hw/tamaPet.sv
  - target: test
    files:
      - verif/tamaPetTb_sva.sv
      - verif/tamaPetTb.sv

// ==== hw/buttonSync.sv ====
// Brings the toy's buttons and switches into the clk domain; buttons come out as edge pulses
`timescale 1ns/1ps

module buttonSync (
	input  logic       clk,
	input  logic       rst,
	input  logic       sleepBtn,
	input  logic       awakeBtn,
	input  logic       feedBtn,
	input  logic       playBtn,
	input  logic       testBtn,
	input  logic       playSwitch,
	input  logic [3:0] testCode,
	output logic       sleepPulse,
	output logic       awakePulse,
	output logic       feedPulse,
	output logic       playPulse,
	output logic       testPulse,
	output logic       playLevel,
	output logic [3:0] testCodeSync
);

	logic [4:0] btnMeta;
	logic [4:0] btnSync;
	logic [4:0] btnLast;
	logic [4:0] btnRise;
	logic [4:0] levelMeta;
	logic [4:0] levelSync;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			btnMeta   <= '0;
			btnSync   <= '0;
			btnLast   <= '0;
			levelMeta <= '0;
			levelSync <= '0;
		end else begin
			btnMeta   <= {testBtn, playBtn, feedBtn, awakeBtn, sleepBtn};
			btnSync   <= btnMeta;
			// Third stage only for the buttons
			btnLast   <= btnSync;
			levelMeta <= {playSwitch, testCode};
			levelSync <= levelMeta;
		end
	end

	assign btnRise = btnSync & ~btnLast;

	assign sleepPulse   = btnRise[0];
	assign awakePulse   = btnRise[1];
	assign feedPulse    = btnRise[2];
	assign playPulse    = btnRise[3];
	assign testPulse    = btnRise[4];
	assign playLevel    = levelSync[4];
	assign testCodeSync = levelSync[3:0];

endmodule

// ==== hw/moodFsm.sv ====
// Mood state machine of the pet; picks the mood from button pulses and need levels
`timescale 1ns/1ps

module moodFsm (
	input logic        clk,
	input logic        rst,
	input logic        sleepPulse,
	input logic        awakePulse,
	input logic        playPulse,
	input logic        testPulse,
	input logic        playLevel,
	input logic [3:0]  testCodeSync,
	petNeedsIf.moodSide needs
);

	tamaPetPkg::moodT nextMood;
	tamaPetPkg::moodT levelMood;
	logic             lowEnergy;
	logic             lowHunger;
	logic             lowFun;
	logic [1:0]       lowCount;
	logic             allFull;
	logic             anyEmpty;
	logic             codeValid;
	logic             energyFull;
	logic             funFull;

	// Level summaries
	assign lowEnergy  = (needs.energy <= tamaPetPkg::LEVEL_W'(tamaPetPkg::LEVEL_LOW));
	assign lowHunger  = (needs.hunger <= tamaPetPkg::LEVEL_W'(tamaPetPkg::LEVEL_LOW));
	assign lowFun     = (needs.fun <= tamaPetPkg::LEVEL_W'(tamaPetPkg::LEVEL_LOW));
	assign lowCount   = 2'(lowEnergy) + 2'(lowHunger) + 2'(lowFun);
	assign energyFull = (needs.energy == tamaPetPkg::LEVEL_W'(tamaPetPkg::LEVEL_MAX));
	assign funFull    = (needs.fun == tamaPetPkg::LEVEL_W'(tamaPetPkg::LEVEL_MAX));
	assign allFull    = energyFull && funFull &&
		(needs.hunger == tamaPetPkg::LEVEL_W'(tamaPetPkg::LEVEL_MAX));
	assign anyEmpty   = (needs.energy == '0) || (needs.hunger == '0) || (needs.fun == '0);

	// Codes 1 to 9 select a preset, anything else keeps waiting
	assign codeValid = (testCodeSync != 4'd0) &&
		(testCodeSync <= 4'(tamaPetPkg::PRESET_LAST));

	// Mood that the levels alone call for
	always_comb begin
		if (allFull) begin
			levelMood = tamaPetPkg::IDLE;
		end else if (lowCount >= 2'd2) begin
			levelMood = tamaPetPkg::SAD;
		end else if (lowEnergy) begin
			levelMood = tamaPetPkg::TIRED;
		end else if (lowHunger) begin
			levelMood = tamaPetPkg::HUNGRY;
		end else if (lowFun) begin
			levelMood = tamaPetPkg::BORED;
		end else begin
			levelMood = tamaPetPkg::NEUTRAL;
		end
	end

	// Transitions in priority order
	always_comb begin
		if (needs.mood == tamaPetPkg::DEATH) begin
			nextMood = tamaPetPkg::DEATH;
		end else if (anyEmpty) begin
			nextMood = tamaPetPkg::DEATH;
		end else if (needs.mood == tamaPetPkg::TEST) begin
			if (codeValid) begin
				nextMood = tamaPetPkg::PRESETS[testCodeSync].mood;
			end else begin
				nextMood = tamaPetPkg::TEST;
			end
		end else if (testPulse) begin
			nextMood = tamaPetPkg::TEST;
		end else if (sleepPulse) begin
			nextMood = tamaPetPkg::SLEEP;
		end else if (playPulse && playLevel) begin
			nextMood = tamaPetPkg::PLAYING;
		end else if (needs.mood == tamaPetPkg::SLEEP && !awakePulse && !energyFull) begin
			nextMood = tamaPetPkg::SLEEP;
		end else if (needs.mood == tamaPetPkg::PLAYING && playLevel && !funFull) begin
			nextMood = tamaPetPkg::PLAYING;
		end else begin
			nextMood = levelMood;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			needs.mood <= tamaPetPkg::IDLE;
		end else begin
			needs.mood <= nextMood;
		end
	end

	// Keeper loads levels on the same edge as the preset mood
	assign needs.presetLoad = (needs.mood == tamaPetPkg::TEST) && !anyEmpty && codeValid;
	assign needs.presetCode = testCodeSync;

endmodule

// ==== hw/needsKeeper.sv ====
// Keeps energy, hunger and fun: slow decay per need, refill by sleep, play and food, test presets
`timescale 1ns/1ps

module needsKeeper (
	input logic      clk,
	input logic      rst,
	input logic      feedPulse,
	petNeedsIf.keeper needs
);

	logic [tamaPetPkg::TICK_W-1:0] tickCnt;
	logic                          tick;
	logic                          frozen;
	tamaPetPkg::presetT            preset;

	// Per-need controls, index 0 energy, 1 hunger, 2 fun
	logic [tamaPetPkg::LEVEL_W-1:0] presetLevel [tamaPetPkg::NEED_COUNT];
	logic [tamaPetPkg::NEED_COUNT-1:0] refill;
	logic [tamaPetPkg::NEED_COUNT-1:0] bump;

	// Tick divider, free running from reset
	assign tick = (tickCnt == tamaPetPkg::TICK_W'(tamaPetPkg::TICK_CYCLES - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tickCnt <= '0;
		end else if (tick) begin
			tickCnt <= '0;
		end else begin
			tickCnt <= tickCnt + 1'b1;
		end
	end

	// Nothing moves while dead or while a test code is pending
	assign frozen = (needs.mood == tamaPetPkg::DEATH) || (needs.mood == tamaPetPkg::TEST);

	// Only read when presetLoad is high, which implies a code from 1 to 9
	assign preset         = tamaPetPkg::PRESETS[needs.presetCode];
	assign presetLevel[0] = preset.energy;
	assign presetLevel[1] = preset.hunger;
	assign presetLevel[2] = preset.fun;

	// Sleeping restores energy, playing restores fun
	assign refill = {needs.mood == tamaPetPkg::PLAYING, 1'b0, needs.mood == tamaPetPkg::SLEEP};
	assign bump   = {1'b0, feedPulse, 1'b0};

	for (genvar i = 0; i < tamaPetPkg::NEED_COUNT; i++) begin : gNeed
		logic [tamaPetPkg::LEVEL_W-1:0]  level;
		logic [tamaPetPkg::PERIOD_W-1:0] periodCnt;
		logic                            due;
		logic                            atMax;
		logic                            atZero;

		assign due    = tick &&
			(periodCnt == tamaPetPkg::PERIOD_W'(tamaPetPkg::NEED_PERIODS[i] - 1));
		assign atMax  = (level == tamaPetPkg::LEVEL_W'(tamaPetPkg::LEVEL_MAX));
		assign atZero = (level == '0);

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				level     <= tamaPetPkg::LEVEL_W'(tamaPetPkg::LEVEL_MAX);
				periodCnt <= '0;
			end else if (needs.presetLoad) begin
				// Lands on the same edge as the preset mood
				level     <= presetLevel[i];
				periodCnt <= '0;
			end else if (!frozen) begin
				if (bump[i] && !atMax) begin
					// Food wins over a decay step in the same cycle
					level     <= level + 1'b1;
					periodCnt <= '0;
				end else if (due) begin
					periodCnt <= '0;
					if (refill[i]) begin
						if (!atMax) begin
							level <= level + 1'b1;
						end
					end else if (!atZero) begin
						level <= level - 1'b1;
					end
				end else if (tick) begin
					periodCnt <= periodCnt + 1'b1;
				end
			end
		end
	end

	assign needs.energy = gNeed[0].level;
	assign needs.hunger = gNeed[1].level;
	assign needs.fun    = gNeed[2].level;

endmodule

// ==== hw/petNeedsIf.sv ====
// Link between the mood machine and the needs keeper: levels one way, mood and presets the other
`timescale 1ns/1ps

interface petNeedsIf;

	// Levels owned by the keeper
	logic [tamaPetPkg::LEVEL_W-1:0] energy;
	logic [tamaPetPkg::LEVEL_W-1:0] hunger;
	logic [tamaPetPkg::LEVEL_W-1:0] fun;

	// Mood and preset request owned by the mood machine
	tamaPetPkg::moodT mood;
	logic             presetLoad;
	logic [3:0]       presetCode;

	modport keeper (
		output energy, hunger, fun,
		input  mood, presetLoad, presetCode
	);

	modport moodSide (
		output mood, presetLoad, presetCode,
		input  energy, hunger, fun
	);

endinterface

// ==== hw/tamaPet.sv ====
// Top of the virtual pet core; connect raw buttons and switches, read mood and need levels
`timescale 1ns/1ps

module tamaPet (
	input  logic       clk,
	input  logic       rst,
	input  logic       sleepBtn,
	input  logic       awakeBtn,
	input  logic       feedBtn,
	input  logic       playBtn,
	input  logic       testBtn,
	input  logic       playSwitch,
	input  logic [3:0] testCode,
	output logic [3:0] mood,
	output logic [2:0] energy,
	output logic [2:0] hunger,
	output logic [2:0] fun
);

	logic       sleepPulse;
	logic       awakePulse;
	logic       feedPulse;
	logic       playPulse;
	logic       testPulse;
	logic       playLevel;
	logic [3:0] testCodeSync;

	petNeedsIf needsBus ();

	buttonSync u_buttonSync (
		.clk          (clk),
		.rst          (rst),
		.sleepBtn     (sleepBtn),
		.awakeBtn     (awakeBtn),
		.feedBtn      (feedBtn),
		.playBtn      (playBtn),
		.testBtn      (testBtn),
		.playSwitch   (playSwitch),
		.testCode     (testCode),
		.sleepPulse   (sleepPulse),
		.awakePulse   (awakePulse),
		.feedPulse    (feedPulse),
		.playPulse    (playPulse),
		.testPulse    (testPulse),
		.playLevel    (playLevel),
		.testCodeSync (testCodeSync)
	);

	moodFsm u_moodFsm (
		.clk          (clk),
		.rst          (rst),
		.sleepPulse   (sleepPulse),
		.awakePulse   (awakePulse),
		.playPulse    (playPulse),
		.testPulse    (testPulse),
		.playLevel    (playLevel),
		.testCodeSync (testCodeSync),
		.needs        (needsBus.moodSide)
	);

	// Feeding bypasses the mood machine
	needsKeeper u_needsKeeper (
		.clk       (clk),
		.rst       (rst),
		.feedPulse (feedPulse),
		.needs     (needsBus.keeper)
	);

	assign mood   = needsBus.mood;
	assign energy = needsBus.energy;
	assign hunger = needsBus.hunger;
	assign fun    = needsBus.fun;

endmodule

// ==== hw/tamaPetPkg.sv ====
// Shared mood encoding, level limits, timing periods and test presets for the pet core
package tamaPetPkg;

	// Mood encoding, numbered as on the toy's mood display
	typedef enum logic [3:0] {
		IDLE    = 4'd0,
		NEUTRAL = 4'd1,
		TIRED   = 4'd2,
		SLEEP   = 4'd3,
		HUNGRY  = 4'd4,
		SAD     = 4'd5,
		PLAYING = 4'd6,
		BORED   = 4'd7,
		DEATH   = 4'd8,
		TEST    = 4'd9
	} moodT;

	// Need levels
	localparam int LEVEL_W   = 3;
	localparam int LEVEL_MAX = 5;
	localparam int LEVEL_LOW = 2;

	// Timing, in clk cycles per tick and ticks per need step
	localparam int TICK_CYCLES   = 16;
	localparam int TICK_W        = $clog2(TICK_CYCLES);
	localparam int ENERGY_PERIOD = 8;
	localparam int HUNGER_PERIOD = 4;
	localparam int FUN_PERIOD    = 6;
	localparam int PERIOD_W      = $clog2(ENERGY_PERIOD + 1);

	// Need order is energy, hunger, fun
	localparam int NEED_COUNT = 3;
	localparam int NEED_PERIODS [NEED_COUNT] = '{ENERGY_PERIOD, HUNGER_PERIOD, FUN_PERIOD};

	typedef struct packed {
		moodT               mood;
		logic [LEVEL_W-1:0] energy;
		logic [LEVEL_W-1:0] hunger;
		logic [LEVEL_W-1:0] fun;
	} presetT;

	// Test codes 1 to 9; row 0 is never loaded
	localparam int PRESET_LAST = 9;
	localparam presetT PRESETS [0:PRESET_LAST] = '{
		'{IDLE,    3'd5, 3'd5, 3'd5},
		'{IDLE,    3'd5, 3'd5, 3'd5},
		'{NEUTRAL, 3'd4, 3'd4, 3'd4},
		'{TIRED,   3'd2, 3'd5, 3'd5},
		'{SLEEP,   3'd2, 3'd5, 3'd5},
		'{HUNGRY,  3'd5, 3'd2, 3'd5},
		'{SAD,     3'd2, 3'd2, 3'd5},
		'{PLAYING, 3'd5, 3'd5, 3'd2},
		'{BORED,   3'd5, 3'd5, 3'd2},
		'{DEATH,   3'd0, 3'd0, 3'd0}
	};

endpackage

// ==== tamaPet.f ====
hw/tamaPetPkg.sv
hw/petNeedsIf.sv
hw/buttonSync.sv
hw/needsKeeper.sv
hw/moodFsm.sv
hw/tamaPet.sv
verif/tamaPetTb_sva.sv
verif/tamaPetTb.sv

// ==== verif/tamaPetTb.sv ====
// Testbench for the pet core; replays the vector rows and checks mood and need levels
`timescale 1ns/1ps

module tamaPetTb;

	// Timing repeated from the design for the bounded waits
	localparam int TICK_CYCLES = 16;
	localparam int PRESS_WAIT  = 6;
	localparam int SYNC_CYCLES = 3;
	localparam int WATCHDOG    = 20000;
	localparam int DONT_CARE   = 'hF;
	localparam logic [31:0] SEED = 32'haf185d33;

	logic       clk;
	logic       rst;
	logic [4:0] buttons;
	logic       playSwitch;
	logic [3:0] testCode;
	logic [3:0] mood;
	logic [2:0] energy;
	logic [2:0] hunger;
	logic [2:0] fun;

	int    errors;
	int    rowsRun;
	int    rowsFailed;
	string rowName;
	string rowAction;
	int    rowArg;
	int    expMood;
	int    expEnergy;
	int    expHunger;
	int    expFun;

	// Button order is sleep, awake, feed, play, test
	tamaPet u_tamaPet (
		.clk        (clk),
		.rst        (rst),
		.sleepBtn   (buttons[0]),
		.awakeBtn   (buttons[1]),
		.feedBtn    (buttons[2]),
		.playBtn    (buttons[3]),
		.testBtn    (buttons[4]),
		.playSwitch (playSwitch),
		.testCode   (testCode),
		.mood       (mood),
		.energy     (energy),
		.hunger     (hunger),
		.fun        (fun)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic bit fieldOk(int expected, int actual);
		return (expected == DONT_CARE) || (expected == actual);
	endfunction

	function automatic bit rowMatches();
		return fieldOk(expMood, mood) && fieldOk(expEnergy, energy) &&
			fieldOk(expHunger, hunger) && fieldOk(expFun, fun);
	endfunction

	// Polls once per falling edge until the row matches or the limit runs out
	task automatic waitForMatch(input int limit);
		int cycles;
		cycles = 0;
		while (!rowMatches() && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		assert (rowMatches()) else begin
			$display("%s: outputs did not reach the expected values within %0d cycles",
				rowName, limit);
			errors++;
		end
	endtask

	// Outputs must keep the expected values for the whole span
	task automatic holdMatch(input int span);
		int cycles;
		cycles = 0;
		while (rowMatches() && cycles < span) begin
			@(negedge clk);
			cycles++;
		end
		assert (rowMatches()) else begin
			$display("%s: outputs left the expected values after %0d cycles", rowName, cycles);
			errors++;
		end
	endtask

	task automatic checkField(input string field, input int expected, input int actual);
		assert (fieldOk(expected, actual)) else begin
			$display("Mismatch %s %s expected %0d actual %0d", rowName, field, expected, actual);
			errors++;
		end
	endtask

	task automatic pressButton(input int index);
		int gap;
		int hold;
		gap  = $urandom_range(4, 1);
		hold = $urandom_range(6, 3);
		repeat (gap) @(negedge clk);
		buttons[index] = 1'b1;
		repeat (hold) @(negedge clk);
		buttons[index] = 1'b0;
		waitForMatch(PRESS_WAIT);
	endtask

	task automatic applyReset();
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		waitForMatch(PRESS_WAIT);
	endtask

	task automatic runRow();
		int errorsBefore;
		errorsBefore = errors;
		case (rowAction)
			"reset": applyReset();
			"press": begin
				if (rowArg > 4) begin
					$display("%s: press row names an unknown button %0d", rowName, rowArg);
					errors++;
				end else begin
					pressButton(rowArg);
				end
			end
			"code": begin
				testCode = 4'(rowArg);
				repeat (SYNC_CYCLES) @(negedge clk);
				waitForMatch(PRESS_WAIT);
			end
			"switch": begin
				playSwitch = rowArg[0];
				repeat (SYNC_CYCLES) @(negedge clk);
				waitForMatch(PRESS_WAIT);
			end
			"wait": begin
				// A row that already matches has to keep matching
				if (rowMatches()) begin
					holdMatch(rowArg * TICK_CYCLES + PRESS_WAIT);
				end else begin
					waitForMatch(rowArg * TICK_CYCLES + PRESS_WAIT);
				end
			end
			default: begin
				$display("%s: unknown action %s in the vector file", rowName, rowAction);
				errors++;
			end
		endcase
		checkField("mood", expMood, mood);
		checkField("energy", expEnergy, energy);
		checkField("hunger", expHunger, hunger);
		checkField("fun", expFun, fun);
		rowsRun++;
		if (errors == errorsBefore) begin
			$display("%s %s ok", rowName, rowAction);
		end else begin
			rowsFailed++;
			$display("%s %s FAILED", rowName, rowAction);
		end
	endtask

	initial begin
		int    fd;
		int    fields;
		string line;
		void'($urandom(SEED));
		rst        = 1'b1;
		buttons    = '0;
		playSwitch = 1'b0;
		testCode   = '0;
		errors     = 0;
		rowsRun    = 0;
		rowsFailed = 0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		fd = $fopen("verif/tamaPetVectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file verif/tamaPetVectors.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Lines starting with a hash are column notes
				if (line.len() > 0 && line[0] != "#") begin
					fields = $sscanf(line, "%s %s %h %h %h %h %h", rowName, rowAction,
						rowArg, expMood, expEnergy, expHunger, expFun);
					if (fields == 7) begin
						runRow();
					end else if (fields > 0) begin
						$display("Malformed vector row: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
			if (rowsRun == 0) begin
				$display("The vector file holds no rows");
				errors++;
			end
		end
		$display("Rows run %0d, rows failed %0d, check errors %0d", rowsRun, rowsFailed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Ends a run that stalls
	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("Watchdog expired before all vector rows ran");
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== verif/tamaPetTb_sva.sv ====
// Concurrent checks bound into the mood machine and the needs keeper of the pet core
`timescale 1ns/1ps

module tamaPetSva (
	input logic                           clk,
	input logic                           rst,
	input logic [3:0]                     mood,
	input logic                           presetLoad,
	input logic [tamaPetPkg::LEVEL_W-1:0] energy,
	input logic [tamaPetPkg::LEVEL_W-1:0] hunger,
	input logic [tamaPetPkg::LEVEL_W-1:0] fun
);

	levelInRange: assert property (@(posedge clk) disable iff (rst)
		(energy <= tamaPetPkg::LEVEL_MAX) && (hunger <= tamaPetPkg::LEVEL_MAX) &&
		(fun <= tamaPetPkg::LEVEL_MAX))
		else $error("A need level is above its maximum");

	// Only reset leaves DEATH, and the levels stay frozen meanwhile
	deathSticky: assert property (@(posedge clk) disable iff (rst)
		(mood == tamaPetPkg::DEATH) |=> (mood == tamaPetPkg::DEATH) &&
		$stable(energy) && $stable(hunger) && $stable(fun))
		else $error("Mood or a level changed in DEATH without a reset");

	// A preset is taken in TEST and moves the mood out of TEST on the next edge
	presetFromTest: assert property (@(posedge clk) disable iff (rst)
		presetLoad |-> (mood == tamaPetPkg::TEST) ##1 (mood != tamaPetPkg::TEST))
		else $error("Preset load outside TEST or without leaving TEST");

endmodule

bind moodFsm tamaPetSva moodChecks (
	.clk        (clk),
	.rst        (rst),
	.mood       (needs.mood),
	.presetLoad (needs.presetLoad),
	.energy     (needs.energy),
	.hunger     (needs.hunger),
	.fun        (needs.fun)
);

bind needsKeeper tamaPetSva keeperChecks (
	.clk        (clk),
	.rst        (rst),
	.mood       (needs.mood),
	.presetLoad (needs.presetLoad),
	.energy     (needs.energy),
	.hunger     (needs.hunger),
	.fun        (needs.fun)
);

// ==== verif/tamaPetVectors.txt ====
# name action arg mood energy hunger fun, all numbers hex, F marks a don't care
# press arg 0 sleep 1 awake 2 feed 3 play 4 test; wait arg in ticks; mood 8 DEATH 9 TEST
afterReset   reset  0 0 5 5 5
enterTest1   press  4 9 5 5 5
codeAbove9   code   A 9 5 5 5
preset1      code   1 0 5 5 5
clearCode1   code   0 0 5 5 5
enterTest2   press  4 9 5 5 5
preset2      code   2 1 4 4 4
clearCode2   code   0 1 4 4 4
enterTest3   press  4 9 4 4 4
preset3      code   3 2 2 5 5
clearCode3   code   0 2 2 5 5
enterTest4   press  4 9 2 5 5
preset4      code   4 3 2 5 5
clearCode4   code   0 3 2 5 5
enterTest5   press  4 9 2 5 5
preset6      code   6 5 2 2 5
clearCode6   code   0 5 2 2 5
enterTest6   press  4 9 2 2 5
preset8      code   8 7 5 5 2
clearCode8   code   0 7 5 5 2
enterTest7   press  4 9 5 5 2
preset5      code   5 4 5 2 5
feed1        press  2 1 5 3 5
feed2        press  2 1 5 4 5
feed3        press  2 0 5 5 5
feed4        press  2 0 5 5 5
clearCode5   code   0 F F F F
enterTest8   press  4 9 F F F
preset2b     code   2 1 4 4 4
hungerDecay  wait   5 1 4 3 4
goSleep      press  0 3 4 3 4
energyRefill wait   5 3 5 F F
wakeHungry   wait   1 4 5 2 3
clearCode2b  code   0 4 F F F
enterTest9   press  4 9 F F F
switchOn     switch 1 9 F F F
preset7      code   7 6 5 5 2
funRefill    wait   7 6 5 4 3
switchOff    switch 0 1 5 4 3
clearCode7   code   0 1 F F F
enterTest10  press  4 9 F F F
preset9      code   9 8 0 0 0
deadFeed     press  2 8 0 0 0
deadTest     press  4 8 0 0 0
deadSleep    press  0 8 0 0 0
deadCode     code   3 8 0 0 0
deadSwitch   switch 1 8 0 0 0
deadPlay     press  3 8 0 0 0
deadWait     wait   A 8 0 0 0
finalReset   reset  0 0 5 5 5
